/* src/csr_defines.svh */
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// register width of the hart
`define CSR_XLEN 64

// mcause exception code for an illegal instruction
`define CSR_CAUSE_ILLEGAL 2

// direct-mode trap base after reset
`define CSR_MTVEC_RESET 64'h0000_0000_8000_0000

`endif

/* src/csr_addr_pkg.sv */
`default_nettype none

package csr_addr_pkg;

    // privilege level with 2'b10 reserved and read as user
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_e;

    typedef struct packed {
        logic [1:0] access;   // 2'b11 marks read-only
        logic [1:0] min_priv; // lowest level allowed
        logic [7:0] index;
    } csr_addr_fields_t;

    // raw view for matching, field view for the access rules
    typedef union packed {
        logic [11:0]      raw;
        csr_addr_fields_t f;
    } csr_addr_u;

    localparam logic [11:0] MSTATUS       = 12'h300;
    localparam logic [11:0] MTVEC         = 12'h305;
    localparam logic [11:0] MCOUNTINHIBIT = 12'h320;
    localparam logic [11:0] MSCRATCH      = 12'h340;
    localparam logic [11:0] MEPC          = 12'h341;
    localparam logic [11:0] MCAUSE        = 12'h342;
    localparam logic [11:0] MTVAL         = 12'h343;
    localparam logic [11:0] MCYCLE        = 12'hB00;
    localparam logic [11:0] MINSTRET      = 12'hB02;

    localparam logic [11:0] SSTATUS       = 12'h100;
    localparam logic [11:0] STVEC         = 12'h105;
    localparam logic [11:0] SSCRATCH      = 12'h140;
    localparam logic [11:0] SEPC          = 12'h141;
    localparam logic [11:0] SCAUSE        = 12'h142;

    localparam logic [11:0] CYCLE         = 12'hC00; // user shadows
    localparam logic [11:0] INSTRET       = 12'hC02;

endpackage

`default_nettype wire

/* src/csr_reg_pkg.sv */
`include "csr_defines.svh"
`default_nettype none

package csr_reg_pkg;
    import csr_addr_pkg::*;

    typedef struct packed {
        logic                 valid;
        logic                 we;
        csr_addr_u            addr;
        logic [`CSR_XLEN-1:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0] rdata;
        logic                 illegal;
    } csr_rsp_t;

    // write broadcast to the register banks
    typedef struct packed {
        logic                 en;
        csr_addr_u            addr;
        logic [`CSR_XLEN-1:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic                 enter;
        logic [`CSR_XLEN-1:0] epc;
        logic [`CSR_XLEN-1:0] tval;
        priv_e                prev_priv;
    } trap_upd_t;

    typedef struct packed {
        logic                 valid;
        logic [`CSR_XLEN-1:0] target_pc;
    } trap_out_t;

    typedef struct packed {
        logic [50:0] rsvd_hi;
        logic [1:0]  mpp;       // bits 12:11
        logic [1:0]  rsvd_10_9;
        logic        spp;       // bit 8
        logic        mpie;
        logic        rsvd_6;
        logic        spie;      // bit 5
        logic        rsvd_4;
        logic        mie;       // bit 3
        logic        rsvd_2;
        logic        sie;       // bit 1
        logic        rsvd_0;
    } mstatus_t;

endpackage

`default_nettype wire

/* src/csr_access_unit.sv */
`include "csr_defines.svh"
`default_nettype none

module csr_access_unit
    import csr_addr_pkg::*;
    import csr_reg_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire csr_req_t             req,
    input  wire priv_e                priv,
    input  wire                       ready,
    input  wire [`CSR_XLEN-1:0]       m_rdata,
    input  wire [`CSR_XLEN-1:0]       s_rdata,
    input  wire [`CSR_XLEN-1:0]       cnt_rdata,
    input  wire                       m_hit,
    input  wire                       s_hit,
    input  wire                       cnt_hit,
    output csr_rsp_t                  rsp,
    output csr_wr_t                   wr,
    output logic                      illegal_req
);

    logic  accept;
    logic  hit_any;
    logic  priv_ok;
    logic  ro_viol;
    logic  illegal;
    priv_e eff_priv;

    assign accept = req.valid && ready; // sequencer busy stalls the port

    always_comb begin
        eff_priv = priv;
        if (priv == 2'b10) begin
            eff_priv = PRIV_U; // reserved level behaves as user
        end
    end

    assign hit_any = m_hit || s_hit || cnt_hit;
    assign priv_ok = (eff_priv >= req.addr.f.min_priv);
    assign ro_viol = req.we && (req.addr.f.access == 2'b11);
    assign illegal = !hit_any || !priv_ok || ro_viol;

    always_comb begin
        rsp.illegal = illegal;
        if (illegal) begin
            rsp.rdata = '0; // no data leaks on a refused access
        end else if (m_hit) begin
            rsp.rdata = m_rdata;
        end else if (s_hit) begin
            rsp.rdata = s_rdata;
        end else begin
            rsp.rdata = cnt_rdata;
        end
    end

    assign wr.en   = accept && req.we && !illegal;
    assign wr.addr = req.addr;
    assign wr.data = req.wdata;

    assign illegal_req = accept && illegal; // kicks off trap entry

    // banks decode disjoint address sets
    a_one_hit: assert property (@(posedge clk) disable iff (rst)
        $onehot0({m_hit, s_hit, cnt_hit}));

    a_wr_xor_trap: assert property (@(posedge clk) disable iff (rst)
        !(wr.en && illegal_req));

endmodule

`default_nettype wire

/* src/csr_trap_fsm.sv */
`include "csr_defines.svh"
`default_nettype none

module csr_trap_fsm
    import csr_addr_pkg::*;
    import csr_reg_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 illegal_req,
    input  wire [`CSR_XLEN-1:0] pc,
    input  wire csr_addr_u      addr,
    input  wire priv_e          priv,
    input  wire [`CSR_XLEN-1:0] mtvec,
    output logic                ready,
    output trap_out_t           trap,
    output trap_upd_t           upd
);

    typedef enum logic {
        IDLE,
        ENTER
    } state_e;

    state_e               state;
    logic [`CSR_XLEN-1:0] cap_pc;
    csr_addr_u            cap_addr;
    priv_e                cap_priv;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (illegal_req) state <= ENTER;
                default: state <= IDLE; // entry is a single cycle
            endcase
        end
    end

    // context of the offending request
    always_ff @(posedge clk) begin
        if (illegal_req) begin
            cap_pc   <= pc;
            cap_addr <= addr;
            cap_priv <= (priv == 2'b10) ? PRIV_U : priv;
        end
    end

    assign ready = (state == IDLE);

    assign trap.valid     = (state == ENTER);
    assign trap.target_pc = {mtvec[`CSR_XLEN-1:2], 2'b00}; // direct mode only

    assign upd.enter     = (state == ENTER);
    assign upd.epc       = cap_pc;
    assign upd.tval      = {{(`CSR_XLEN-12){1'b0}}, cap_addr.raw};
    assign upd.prev_priv = cap_priv;

    a_trap_one_cycle: assert property (@(posedge clk) disable iff (rst)
        trap.valid |=> !trap.valid);

endmodule

`default_nettype wire

/* src/csr_counters.sv */
`include "csr_defines.svh"
`default_nettype none

module csr_counters
    import csr_addr_pkg::*;
    import csr_reg_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire csr_wr_t         wr,
    input  wire                  instr_retired,
    input  wire csr_addr_u       addr,
    output logic [`CSR_XLEN-1:0] rdata,
    output logic                 hit
);

    logic [`CSR_XLEN-1:0] mcycle;
    logic [`CSR_XLEN-1:0] minstret;
    logic                 inh_cy; // mcountinhibit.CY
    logic                 inh_ir; // mcountinhibit.IR

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= '0;
            minstret <= '0;
            inh_cy   <= 1'b0;
            inh_ir   <= 1'b0;
        end else begin
            if (wr.en && wr.addr.raw == MCYCLE) begin
                mcycle <= wr.data; // write beats the increment
            end else if (!inh_cy) begin
                mcycle <= mcycle + `CSR_XLEN'd1;
            end
            if (wr.en && wr.addr.raw == MINSTRET) begin
                minstret <= wr.data;
            end else if (instr_retired && !inh_ir) begin
                minstret <= minstret + `CSR_XLEN'd1;
            end
            if (wr.en && wr.addr.raw == MCOUNTINHIBIT) begin
                inh_cy <= wr.data[0];
                inh_ir <= wr.data[2];
            end
        end
    end

    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (addr.raw)
            MCYCLE, CYCLE:     rdata = mcycle;
            MINSTRET, INSTRET: rdata = minstret;
            MCOUNTINHIBIT:     rdata = {{(`CSR_XLEN-3){1'b0}}, inh_ir, 1'b0, inh_cy};
            default:           hit = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* src/csr_machine_regs.sv */
`include "csr_defines.svh"
`default_nettype none

module csr_machine_regs
    import csr_addr_pkg::*;
    import csr_reg_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire csr_wr_t         wr,
    input  wire trap_upd_t       upd,
    input  wire csr_addr_u       addr,
    input  wire mstatus_t        sstatus_wr,
    input  wire                  sstatus_we,
    output logic [`CSR_XLEN-1:0] rdata,
    output logic                 hit,
    output mstatus_t             mstatus,
    output logic [`CSR_XLEN-1:0] mtvec
);

    localparam logic [`CSR_XLEN-1:0] CAUSE_ILLEGAL = `CSR_CAUSE_ILLEGAL;

    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mtval;
    logic [`CSR_XLEN-1:0] mscratch;
    mstatus_t             wr_st;

    assign wr_st = wr.data; // field view of the write data

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus  <= '0;
            mtvec    <= `CSR_MTVEC_RESET;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mscratch <= '0;
        end else if (upd.enter) begin
            mepc         <= upd.epc;
            mcause       <= CAUSE_ILLEGAL;
            mtval        <= upd.tval;
            mstatus.mpie <= mstatus.mie; // push interrupt enable
            mstatus.mie  <= 1'b0;
            mstatus.mpp  <= upd.prev_priv;
        end else begin
            if (wr.en) begin
                case (wr.addr.raw)
                    MSTATUS: begin
                        mstatus.sie  <= wr_st.sie;
                        mstatus.mie  <= wr_st.mie;
                        mstatus.spie <= wr_st.spie;
                        mstatus.mpie <= wr_st.mpie;
                        mstatus.spp  <= wr_st.spp;
                        mstatus.mpp  <= wr_st.mpp;
                    end
                    MTVEC:    mtvec    <= wr.data;
                    MEPC:     mepc     <= wr.data;
                    MCAUSE:   mcause   <= wr.data;
                    MTVAL:    mtval    <= wr.data;
                    MSCRATCH: mscratch <= wr.data;
                    default:  ;
                endcase
            end
            if (sstatus_we) begin
                // supervisor view only reaches these three
                mstatus.sie  <= sstatus_wr.sie;
                mstatus.spie <= sstatus_wr.spie;
                mstatus.spp  <= sstatus_wr.spp;
            end
        end
    end

    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (addr.raw)
            MSTATUS:  rdata = mstatus;
            MTVEC:    rdata = mtvec;
            MEPC:     rdata = mepc;
            MCAUSE:   rdata = mcause;
            MTVAL:    rdata = mtval;
            MSCRATCH: rdata = mscratch;
            default:  hit = 1'b0;
        endcase
    end

    a_mstatus_rsvd: assert property (@(posedge clk) disable iff (rst)
        {mstatus.rsvd_hi, mstatus.rsvd_10_9, mstatus.rsvd_6,
         mstatus.rsvd_4, mstatus.rsvd_2, mstatus.rsvd_0} == '0);

endmodule

`default_nettype wire

/* src/csr_supervisor_regs.sv */
`include "csr_defines.svh"
`default_nettype none

module csr_supervisor_regs
    import csr_addr_pkg::*;
    import csr_reg_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire csr_wr_t         wr,
    input  wire csr_addr_u       addr,
    input  wire mstatus_t        mstatus,
    output logic [`CSR_XLEN-1:0] rdata,
    output logic                 hit,
    output mstatus_t             sstatus_wr,
    output logic                 sstatus_we
);

    logic [`CSR_XLEN-1:0] stvec;
    logic [`CSR_XLEN-1:0] sepc;
    logic [`CSR_XLEN-1:0] scause;
    logic [`CSR_XLEN-1:0] sscratch;
    mstatus_t             wr_st;
    mstatus_t             sstatus; // restricted view of mstatus

    assign wr_st = wr.data;

    always_comb begin
        sstatus      = '0;
        sstatus.sie  = mstatus.sie;
        sstatus.spie = mstatus.spie;
        sstatus.spp  = mstatus.spp;
    end

    // masked update forwarded to the machine bank
    always_comb begin
        sstatus_wr      = '0;
        sstatus_wr.sie  = wr_st.sie;
        sstatus_wr.spie = wr_st.spie;
        sstatus_wr.spp  = wr_st.spp;
    end

    assign sstatus_we = wr.en && (wr.addr.raw == SSTATUS);

    always_ff @(posedge clk) begin
        if (rst) begin
            stvec    <= '0;
            sepc     <= '0;
            scause   <= '0;
            sscratch <= '0;
        end else if (wr.en) begin
            case (wr.addr.raw)
                STVEC:    stvec    <= wr.data;
                SEPC:     sepc     <= wr.data;
                SCAUSE:   scause   <= wr.data;
                SSCRATCH: sscratch <= wr.data;
                default:  ;
            endcase
        end
    end

    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (addr.raw)
            SSTATUS:  rdata = sstatus;
            STVEC:    rdata = stvec;
            SEPC:     rdata = sepc;
            SCAUSE:   rdata = scause;
            SSCRATCH: rdata = sscratch;
            default:  hit = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* src/csr_top.sv */
`include "csr_defines.svh"
`default_nettype none

module csr_top
    import csr_addr_pkg::*;
    import csr_reg_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire csr_req_t       req,
    input  wire [`CSR_XLEN-1:0] pc,
    input  wire                 instr_retired,
    input  wire priv_e          priv,
    output csr_rsp_t            rsp,
    output logic                ready,
    output trap_out_t           trap
);

    logic [`CSR_XLEN-1:0] m_rdata;
    logic [`CSR_XLEN-1:0] s_rdata;
    logic [`CSR_XLEN-1:0] cnt_rdata;
    logic                 m_hit;
    logic                 s_hit;
    logic                 cnt_hit;
    logic                 illegal_req;
    logic                 sstatus_we;
    logic [`CSR_XLEN-1:0] mtvec;
    csr_wr_t              wr;
    trap_upd_t            upd;
    mstatus_t             mstatus;
    mstatus_t             sstatus_wr;

    csr_access_unit u_access (
        .clk(clk), .rst(rst), .req(req), .priv(priv), .ready(ready),
        .m_rdata(m_rdata), .s_rdata(s_rdata), .cnt_rdata(cnt_rdata),
        .m_hit(m_hit), .s_hit(s_hit), .cnt_hit(cnt_hit),
        .rsp(rsp), .wr(wr), .illegal_req(illegal_req)
    );

    csr_trap_fsm u_trap (
        .clk(clk), .rst(rst), .illegal_req(illegal_req), .pc(pc),
        .addr(req.addr), .priv(priv), .mtvec(mtvec),
        .ready(ready), .trap(trap), .upd(upd)
    );

    csr_counters u_counters (
        .clk(clk), .rst(rst), .wr(wr), .instr_retired(instr_retired),
        .addr(req.addr), .rdata(cnt_rdata), .hit(cnt_hit)
    );

    csr_machine_regs u_machine (
        .clk(clk), .rst(rst), .wr(wr), .upd(upd), .addr(req.addr),
        .sstatus_wr(sstatus_wr), .sstatus_we(sstatus_we),
        .rdata(m_rdata), .hit(m_hit), .mstatus(mstatus), .mtvec(mtvec)
    );

    csr_supervisor_regs u_supervisor (
        .clk(clk), .rst(rst), .wr(wr), .addr(req.addr), .mstatus(mstatus),
        .rdata(s_rdata), .hit(s_hit),
        .sstatus_wr(sstatus_wr), .sstatus_we(sstatus_we)
    );

endmodule

`default_nettype wire

/* testbench/csr_tb.sv */
`include "csr_defines.svh"
`default_nettype none

module csr_tb
    import csr_addr_pkg::*;
    import csr_reg_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 600;
    localparam int RANDOM_REQS     = 300;
    localparam int MAX_CYCLES      = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_REQS * 5 + 100;

    localparam logic [63:0] MSTATUS_MASK = 64'h19AA; // sie mie spie mpie spp mpp
    localparam logic [63:0] SSTATUS_MASK = 64'h0122; // sie spie spp

    localparam logic [11:0] RW_ADDRS [9] = '{MTVEC, MEPC, MCAUSE, MTVAL, MSCRATCH,
                                             STVEC, SEPC, SCAUSE, SSCRATCH};

    // implemented registers first, then a few holes in the map
    localparam logic [11:0] ADDR_POOL [22] = '{MSTATUS, MTVEC, MEPC, MCAUSE, MTVAL,
        MSCRATCH, MCOUNTINHIBIT, MCYCLE, MINSTRET, SSTATUS, STVEC, SEPC, SCAUSE,
        SSCRATCH, CYCLE, INSTRET, 12'h000, 12'h306, 12'h180, 12'hC01, 12'h7C0, 12'hF14};

    typedef struct packed {
        logic        illegal;
        logic [63:0] rdata;
        logic [63:0] wval;  // register contents after a legal write
    } exp_t;

    logic      clk = 1'b0;
    logic      rst;
    csr_req_t  req;
    logic [63:0] pc;
    logic      instr_retired;
    priv_e     priv;
    csr_rsp_t  rsp;
    logic      ready;
    trap_out_t trap;

    // reference register state
    logic [63:0] m_status;
    logic [63:0] m_tvec;
    logic [63:0] m_epc;
    logic [63:0] m_cause;
    logic [63:0] m_tval;
    logic [63:0] m_scratch;
    logic [63:0] s_tvec;
    logic [63:0] s_epc;
    logic [63:0] s_cause;
    logic [63:0] s_scratch;
    logic [63:0] m_cycle;
    logic [63:0] m_instret;
    logic [63:0] m_inhibit;
    logic        in_enter;   // model sits in the trap entry cycle
    logic [63:0] cap_pc;
    logic [11:0] cap_addr;
    logic [1:0]  cap_priv;

    logic [63:0] pc_next;
    string       test_name;

    csr_top u_dut (
        .clk(clk), .rst(rst), .req(req), .pc(pc), .instr_retired(instr_retired),
        .priv(priv), .rsp(rsp), .ready(ready), .trap(trap)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_val(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error [%s] %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [63:0] fill_pattern(input logic [11:0] a);
        return {20'hCAFE0, a, 20'h5A5A5, a};
    endfunction

    function automatic exp_t model_access(input logic [11:0] a, input logic [1:0] p,
                                          input logic we, input logic [63:0] d);
        exp_t       r;
        logic       impl;
        logic [1:0] ep;
        ep      = (p == 2'b10) ? 2'b00 : p; // reserved level acts as user
        impl    = 1'b1;
        r.rdata = '0;
        r.wval  = d;
        case (a)
            MSTATUS: begin
                r.rdata = m_status;
                r.wval  = (m_status & ~MSTATUS_MASK) | (d & MSTATUS_MASK);
            end
            SSTATUS: begin
                r.rdata = m_status & SSTATUS_MASK;
                r.wval  = (m_status & ~SSTATUS_MASK) | (d & SSTATUS_MASK);
            end
            MCOUNTINHIBIT: begin
                r.rdata = m_inhibit;
                r.wval  = d & 64'h5; // only CY and IR exist
            end
            MTVEC:             r.rdata = m_tvec;
            MEPC:              r.rdata = m_epc;
            MCAUSE:            r.rdata = m_cause;
            MTVAL:             r.rdata = m_tval;
            MSCRATCH:          r.rdata = m_scratch;
            STVEC:             r.rdata = s_tvec;
            SEPC:              r.rdata = s_epc;
            SCAUSE:            r.rdata = s_cause;
            SSCRATCH:          r.rdata = s_scratch;
            MCYCLE, CYCLE:     r.rdata = m_cycle;
            MINSTRET, INSTRET: r.rdata = m_instret;
            default:           impl = 1'b0;
        endcase
        r.illegal = !impl || (ep < a[9:8]) || (we && a[11:10] == 2'b11);
        if (r.illegal) begin
            r.rdata = '0;
        end
        return r;
    endfunction

    task automatic model_reset();
        m_status  = '0;
        m_tvec    = `CSR_MTVEC_RESET;
        m_epc     = '0;
        m_cause   = '0;
        m_tval    = '0;
        m_scratch = '0;
        s_tvec    = '0;
        s_epc     = '0;
        s_cause   = '0;
        s_scratch = '0;
        m_cycle   = '0;
        m_instret = '0;
        m_inhibit = '0;
    endtask

    // counters are handled by the compare process
    task automatic model_write(input logic [11:0] a, input logic [63:0] v);
        case (a)
            MSTATUS, SSTATUS: m_status  = v;
            MTVEC:            m_tvec    = v;
            MEPC:             m_epc     = v;
            MCAUSE:           m_cause   = v;
            MTVAL:            m_tval    = v;
            MSCRATCH:         m_scratch = v;
            STVEC:            s_tvec    = v;
            SEPC:             s_epc     = v;
            SCAUSE:           s_cause   = v;
            SSCRATCH:         s_scratch = v;
            MCOUNTINHIBIT:    m_inhibit = v;
            default:          ;
        endcase
    endtask

    task automatic model_trap();
        m_epc           = cap_pc;
        m_cause         = 64'(`CSR_CAUSE_ILLEGAL);
        m_tval          = {52'd0, cap_addr};
        m_status[7]     = m_status[3]; // mpie takes mie
        m_status[3]     = 1'b0;
        m_status[12:11] = (cap_priv == 2'b10) ? 2'b00 : cap_priv;
    endtask

    // sampled mid-cycle once DUT outputs have settled
    always @(negedge clk) begin : compare_proc
        exp_t        e;
        logic        acc;
        logic        enter_next;
        logic [63:0] cy_next;
        logic [63:0] ir_next;
        if (rst) begin
            model_reset();
            in_enter = 1'b0;
        end else begin
            check_val("ready", 64'(!in_enter), 64'(ready));
            check_val("trap valid", 64'(in_enter), 64'(trap.valid));
            cy_next    = m_inhibit[0] ? m_cycle : m_cycle + 64'd1;
            ir_next    = (instr_retired && !m_inhibit[2]) ? m_instret + 64'd1 : m_instret;
            enter_next = 1'b0;
            if (in_enter) begin
                check_val("trap target", m_tvec & ~64'h3, trap.target_pc);
                model_trap();
            end
            acc = req.valid && ready;
            if (acc) begin
                e = model_access(req.addr.raw, priv, req.we, req.wdata);
                check_val("rsp illegal", 64'(e.illegal), 64'(rsp.illegal));
                check_val("rsp rdata", e.rdata, rsp.rdata);
                if (e.illegal) begin
                    enter_next = 1'b1;
                    cap_pc     = pc;
                    cap_addr   = req.addr.raw;
                    cap_priv   = priv;
                end else if (req.we) begin
                    model_write(req.addr.raw, e.wval);
                    if (req.addr.raw == MCYCLE) begin
                        cy_next = e.wval; // write beats increment
                    end
                    if (req.addr.raw == MINSTRET) begin
                        ir_next = e.wval;
                    end
                end
            end
            m_cycle   = cy_next;
            m_instret = ir_next;
            in_enter  = enter_next;
        end
    end

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic access(input logic [11:0] a, input logic [1:0] p, input logic we,
                          input logic [63:0] d, output logic [63:0] rd, output logic ill);
        req.valid    = 1'b1;
        req.we       = we;
        req.addr.raw = a;
        req.wdata    = d;
        priv         = priv_e'(p);
        pc_next      = pc_next + 64'd4;
        pc           = pc_next;
        @(negedge clk);
        while (!ready) @(negedge clk); // held through trap entry
        rd  = rsp.rdata;
        ill = rsp.illegal;
        @(posedge clk);
        #10;
        req.valid = 1'b0;
        req.we    = 1'b0;
    endtask

    task automatic wr_csr(input logic [11:0] a, input logic [63:0] d);
        logic [63:0] rd;
        logic        ill;
        access(a, PRIV_M, 1'b1, d, rd, ill);
        check_val("write accepted", 64'd0, 64'(ill));
    endtask

    task automatic expect_read(input logic [11:0] a, input logic [1:0] p,
                               input logic [63:0] expected);
        logic [63:0] rd;
        logic        ill;
        access(a, p, 1'b0, '0, rd, ill);
        check_val("read legal", 64'd0, 64'(ill));
        check_val("read value", expected, rd);
    endtask

    task automatic expect_illegal(input logic [11:0] a, input logic [1:0] p,
                                  input logic we, input logic [63:0] d);
        logic [63:0] rd;
        logic        ill;
        access(a, p, we, d, rd, ill);
        check_val("illegal flag", 64'd1, 64'(ill));
        check_val("illegal rdata", 64'd0, rd);
    endtask

    task automatic retire_pulses(input int n);
        for (int i = 0; i < n; i++) begin
            instr_retired = 1'b1;
            idle(1);
            instr_retired = 1'b0;
            idle(i % 3);
        end
    endtask

    initial begin : stimulus
        logic [63:0] rd;
        logic        ill;
        logic [63:0] v;
        logic [63:0] x;
        logic [11:0] a;
        logic [1:0]  p;
        logic        we;
        void'($urandom(32'ha903));
        test_name     = "reset";
        rst           = 1'b1;
        req           = '0;
        pc            = '0;
        pc_next       = 64'h1000;
        instr_retired = 1'b0;
        priv          = PRIV_M;
        idle(RESET_CYCLES);
        rst = 1'b0;

        test_name = "machine_rw";
        for (int i = 0; i < 9; i++) begin
            wr_csr(RW_ADDRS[i], fill_pattern(RW_ADDRS[i]));
            expect_read(RW_ADDRS[i], PRIV_M, fill_pattern(RW_ADDRS[i]));
        end
        wr_csr(MSTATUS, '1);
        expect_read(MSTATUS, PRIV_M, 64'h19AA);
        expect_read(SSTATUS, PRIV_M, 64'h0122);
        wr_csr(SSTATUS, '0);
        expect_read(MSTATUS, PRIV_M, 64'h1888);
        wr_csr(MSTATUS, '0);
        wr_csr(SSTATUS, '1);
        expect_read(MSTATUS, PRIV_M, 64'h0122);
        expect_read(SSTATUS, PRIV_S, 64'h0122);
        wr_csr(MSTATUS, '0);

        test_name = "privilege";
        expect_illegal(MSCRATCH, PRIV_S, 1'b0, '0);
        expect_illegal(MSCRATCH, PRIV_S, 1'b1, 64'hBAD);
        expect_illegal(MTVEC, PRIV_U, 1'b1, 64'hBAD);
        expect_illegal(SSCRATCH, PRIV_U, 1'b1, 64'hBAD);
        expect_illegal(STVEC, PRIV_U, 1'b0, '0);
        expect_illegal(SSCRATCH, 2'b10, 1'b1, 64'hBAD); // reserved level
        expect_illegal(MCYCLE, PRIV_S, 1'b0, '0);
        expect_illegal(CYCLE, PRIV_M, 1'b1, 64'hBAD);
        expect_illegal(INSTRET, PRIV_M, 1'b1, 64'hBAD);
        expect_illegal(12'h306, PRIV_M, 1'b0, '0);
        expect_illegal(12'h7C0, PRIV_M, 1'b1, 64'hBAD);
        expect_read(MSCRATCH, PRIV_M, fill_pattern(MSCRATCH));
        expect_read(SSCRATCH, PRIV_S, fill_pattern(SSCRATCH));
        expect_read(MTVEC, PRIV_M, fill_pattern(MTVEC));
        access(CYCLE, PRIV_U, 1'b0, '0, rd, ill);
        check_val("cycle from user", 64'd0, 64'(ill));
        access(INSTRET, PRIV_U, 1'b0, '0, rd, ill);
        check_val("instret from user", 64'd0, 64'(ill));

        test_name = "trap_entry";
        wr_csr(MTVEC, 64'h8000_1237);
        wr_csr(MSTATUS, 64'h8); // mie set
        access(MSTATUS, PRIV_S, 1'b0, '0, rd, ill);
        x = pc_next;
        check_val("illegal", 64'd1, 64'(ill));
        check_val("trap valid", 64'd1, 64'(trap.valid));
        check_val("ready low", 64'd0, 64'(ready));
        check_val("target", 64'h8000_1234, trap.target_pc);
        idle(1);
        check_val("trap over", 64'd0, 64'(trap.valid));
        check_val("ready back", 64'd1, 64'(ready));
        expect_read(MEPC, PRIV_M, x);
        expect_read(MCAUSE, PRIV_M, 64'd2);
        expect_read(MTVAL, PRIV_M, 64'h300);
        expect_read(MSTATUS, PRIV_M, 64'h0880); // mpie set with mpp at supervisor

        test_name = "counters";
        v = 64'h0000_0001_0000_0000;
        wr_csr(MCYCLE, v);
        expect_read(MCYCLE, PRIV_M, v);
        idle(10);
        expect_read(MCYCLE, PRIV_M, v + 64'd11); // ten idle cycles and one request slot
        wr_csr(MINSTRET, '0);
        retire_pulses(7);
        expect_read(INSTRET, PRIV_U, 64'd7);
        wr_csr(MCOUNTINHIBIT, 64'hFF);
        expect_read(MCOUNTINHIBIT, PRIV_M, 64'h5);
        x = m_cycle; // count held by the reference model
        idle(5);
        expect_read(MCYCLE, PRIV_M, x);
        retire_pulses(3);
        expect_read(MINSTRET, PRIV_M, 64'd7);
        wr_csr(MCOUNTINHIBIT, '0);

        test_name = "random_mix";
        for (int n = 0; n < RANDOM_REQS; n++) begin
            a             = ADDR_POOL[$urandom_range(21)];
            p             = 2'($urandom_range(3));
            we            = 1'($urandom_range(1));
            v             = {$urandom, $urandom};
            instr_retired = 1'($urandom_range(1));
            access(a, p, we, v, rd, ill);
            idle(int'($urandom_range(1)));
        end
        instr_retired = 1'b0;
        idle(2); // let a last trap entry finish

        $display("PASS: all tests");
        $finish;
    end

    initial begin : watchdog
        #(MAX_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, the tests did not complete", MAX_CYCLES);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* csr_top.f */
+incdir+src
src/csr_addr_pkg.sv
src/csr_reg_pkg.sv
src/csr_access_unit.sv
src/csr_trap_fsm.sv
src/csr_counters.sv
src/csr_machine_regs.sv
src/csr_supervisor_regs.sv
src/csr_top.sv
testbench/csr_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the CSR testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="FAIL: see errors above"

verilator --binary --timing --assert --top-module csr_tb -f csr_top.f -o csr_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/csr_sim > "$LOG" 2>&1
status=$?

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "simulation reported failure, see $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status, see $LOG"
    exit 1
fi
echo "simulation passed"
exit 0
